// File: logic/rx_testbus_defines.svh
// Widths, depths and register map of the receive-channel debug subsystem
// RX_FIFO_DEPTH must stay a power of two
// Every test bus word is RX_TESTBUS_W bits wide

`ifndef RX_TESTBUS_DEFINES_SVH
`define RX_TESTBUS_DEFINES_SVH

// Bus widths
`define RX_TESTBUS_W        20
`define RX_FIFO_DATA_W      16
`define RX_CFG_ADDR_W       4
`define RX_CFG_DATA_W       8

// FIFO and reset sequencer sizing
`define RX_FIFO_DEPTH       16
`define RX_HRDRST_DELAY     8      // Cycles that fifo_srst is held

// Register map
`define RX_CFG_ADDR_DP_SEL  4'd0   // tb_sel in bits 3..0
`define RX_CFG_ADDR_PCS_SEL 4'd1   // pcs_sel in bits 2..0, pcspma_sel in bit 3

`endif

// File: logic/rx_testbus_pkg.sv
// Shared types of the receive-channel debug subsystem
// Selector codes not listed in tb_src_e drive a zero test bus

`default_nettype none

`include "rx_testbus_defines.svh"

package rx_testbus_pkg;

    // One status word on the internal test bus
    typedef logic [`RX_TESTBUS_W-1:0] testbus_t;

    // ------------------------------------------------------------------------
    // Test bus source selector codes
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        TB_FIFO1  = 4'd0,
        TB_FIFO2  = 4'd1,
        TB_TXCHNL = 4'd8,
        TB_AVMM   = 4'd9,
        TB_HRDRST = 4'd11,
        TB_PLD    = 4'd12,
        TB_DLL    = 4'd13
    } tb_src_e;

    // ------------------------------------------------------------------------
    // Hard-reset sequencer states
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        HR_IDLE  = 2'd0,
        HR_RESET = 2'd1,   // fifo_srst held high
        HR_DONE  = 2'd2    // Ack high until the request drops
    } hrdrst_state_e;

endpackage

`default_nettype wire

// File: logic/rx_cfg_regs.sv
// Configuration registers behind a four-phase req/ack write port
// A new request must wait for cfg_ack low
// Writes to unmapped addresses are acknowledged and only logged

`timescale 1ns/100ps
`default_nettype none

`include "rx_testbus_defines.svh"

module rx_cfg_regs
    import rx_testbus_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        cfg_req,
    input  wire  [`RX_CFG_ADDR_W-1:0]  cfg_addr,
    input  wire  [`RX_CFG_DATA_W-1:0]  cfg_wdata,
    output logic                       cfg_ack,
    output tb_src_e                    tb_sel,
    output logic [2:0]                 pcs_sel,
    output logic                       pcspma_sel,
    output testbus_t                   avmm_testbus
);

    logic                      wr_fire;
    logic [7:0]                wr_cnt;      // Acknowledged writes, wraps
    logic [`RX_CFG_ADDR_W-1:0] last_addr;
    logic [7:0]                last_data;

    assign wr_fire = cfg_req && !cfg_ack;   // First cycle of a new request

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_ack <= 1'b0;
        end else if (wr_fire) begin
            cfg_ack <= 1'b1;
        end else if (cfg_ack && !cfg_req) begin
            cfg_ack <= 1'b0;                // Host has released the request
        end
    end

    // ------------------------------------------------------------------------
    // Select fields and write record
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            tb_sel     <= TB_FIFO1;
            pcs_sel    <= 3'd0;
            pcspma_sel <= 1'b0;
            wr_cnt     <= 8'd0;
            last_addr  <= '0;
            last_data  <= 8'd0;
        end else if (wr_fire) begin
            case (cfg_addr)
                `RX_CFG_ADDR_DP_SEL: begin
                    tb_sel <= tb_src_e'(cfg_wdata[3:0]);
                end
                `RX_CFG_ADDR_PCS_SEL: begin
                    pcs_sel    <= cfg_wdata[2:0];
                    pcspma_sel <= cfg_wdata[3];
                end
                default: ;                  // Logged only
            endcase
            wr_cnt    <= wr_cnt + 8'd1;
            last_addr <= cfg_addr;
            last_data <= cfg_wdata[7:0];
        end
    end

    // Counter 19..12, address 11..8, data 7..0
    assign avmm_testbus = {wr_cnt, last_addr, last_data};

    // Ack only ever answers a request seen on the previous edge
    ack_needs_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req)
    );

endmodule

`default_nettype wire

// File: logic/rx_fifo.sv
// First-word-fall-through receive FIFO, no back-pressure
// Writes into a full FIFO are dropped and set a sticky overflow flag
// DEPTH must be a power of two; the status word carries 5-bit count
// and 4-bit pointer fields, sized for the default depth of 16

`timescale 1ns/100ps
`default_nettype none

`include "rx_testbus_defines.svh"

module rx_fifo
    import rx_testbus_pkg::*;
#(
    parameter int DEPTH = `RX_FIFO_DEPTH
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         fifo_srst,
    input  wire                         rx_data_valid,
    input  wire  [`RX_FIFO_DATA_W-1:0]  rx_data,
    input  wire                         rx_rd_en,
    output logic [`RX_FIFO_DATA_W-1:0]  rx_rd_data,
    output logic                        rx_empty,
    output logic                        rx_full,
    output testbus_t                    fifo_testbus1,
    output testbus_t                    fifo_testbus2
);

    localparam int AW = $clog2(DEPTH);

    logic [`RX_FIFO_DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0]              wr_ptr;
    logic [AW-1:0]              rd_ptr;
    logic [AW:0]                count;
    logic                       overflow;
    logic                       underflow;
    logic                       do_wr;
    logic                       do_rd;
    logic [4:0]                 count_fld;
    logic [3:0]                 wr_ptr_fld;
    logic [3:0]                 rd_ptr_fld;

    assign rx_full  = (count == (AW + 1)'(DEPTH));
    assign rx_empty = (count == '0);

    assign do_wr = rx_data_valid && !rx_full;
    assign do_rd = rx_rd_en && !rx_empty;

    // ------------------------------------------------------------------------
    // Storage, no reset on the payload
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= rx_data;
        end
    end

    assign rx_rd_data = mem[rd_ptr];   // Head word, valid while not empty

    // ------------------------------------------------------------------------
    // Pointers, count and sticky flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || fifo_srst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                 // Both or neither
            endcase
            if (rx_data_valid && rx_full) overflow  <= 1'b1;
            if (rx_rd_en && rx_empty)     underflow <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Status words
    // ------------------------------------------------------------------------
    assign count_fld  = 5'(count);
    assign wr_ptr_fld = 4'(wr_ptr);
    assign rd_ptr_fld = 4'(rd_ptr);

    assign fifo_testbus1 = {3'b000, rd_ptr_fld, wr_ptr_fld, underflow, overflow,
                            rx_empty, rx_full, count_fld};

    // Head word, zero while empty
    assign fifo_testbus2 = {4'b0000, rx_empty ? '0 : rx_rd_data};

    count_in_range: assert property (
        @(posedge clk) disable iff (reset)
        count <= (AW + 1)'(DEPTH)
    );

endmodule

`default_nettype wire

// File: logic/rx_hrdrst_ctrl.sv
// Hard-reset sequencer with a four-phase request
// fifo_srst is held for RX_HRDRST_DELAY cycles, then ack rises
// Ack stays high until the request is withdrawn

`timescale 1ns/100ps
`default_nettype none

`include "rx_testbus_defines.svh"

module rx_hrdrst_ctrl
    import rx_testbus_pkg::*;
(
    input  wire       clk,
    input  wire       reset,
    input  wire       hrdrst_req,
    output logic      hrdrst_ack,
    output logic      fifo_srst,
    output testbus_t  hrdrst_testbus
);

    hrdrst_state_e state;
    logic [7:0]    dly_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= HR_IDLE;
            dly_cnt <= 8'd0;
        end else begin
            case (state)
                HR_IDLE: begin
                    if (hrdrst_req) begin
                        state   <= HR_RESET;
                        dly_cnt <= 8'd0;
                    end
                end
                HR_RESET: begin
                    if (dly_cnt == 8'(`RX_HRDRST_DELAY - 1)) begin
                        state <= HR_DONE;
                    end else begin
                        dly_cnt <= dly_cnt + 8'd1;
                    end
                end
                HR_DONE: begin
                    if (!hrdrst_req) state <= HR_IDLE;   // Ack drops here
                end
                default: state <= HR_IDLE;
            endcase
        end
    end

    assign fifo_srst  = (state == HR_RESET);
    assign hrdrst_ack = (state == HR_DONE);

    // Zero 19..12, ack 11, req 10, counter 9..2, state 1..0
    assign hrdrst_testbus = {8'd0, hrdrst_ack, hrdrst_req, dly_cnt, state};

    // FIFO reset held for exactly RX_HRDRST_DELAY cycles before ack rises
    srst_held_before_ack: assert property (
        @(posedge clk) disable iff (reset)
        $rose(hrdrst_ack) |-> $past(fifo_srst, `RX_HRDRST_DELAY)
                              && !$past(fifo_srst, `RX_HRDRST_DELAY + 1)
    );

endmodule

`default_nettype wire

// File: logic/rx_chnl_testbus.sv
// Receive channel test bus mux and direct-transfer bit slicer
// Purely combinational; unused selector codes give a zero word
// pcspma_sel low routes PMA test bits to the direct-transfer outputs

`timescale 1ns/100ps
`default_nettype none

`include "rx_testbus_defines.svh"

module rx_chnl_testbus
    import rx_testbus_pkg::*;
(
    input  tb_src_e      tb_sel,
    input  wire  [2:0]   pcs_sel,
    input  wire          pcspma_sel,
    input  testbus_t     fifo_testbus1,
    input  testbus_t     fifo_testbus2,
    input  testbus_t     hrdrst_testbus,
    input  testbus_t     avmm_testbus,
    input  testbus_t     tx_chnl_testbus,
    input  testbus_t     pld_test_data,
    input  wire  [7:0]   pld_pma_testbus,
    input  wire  [12:0]  oaibdftdll2core,
    output testbus_t     rx_chnl_testbus,
    output logic [1:0]   rx_direct_transfer_testbus,
    output logic         tx_direct_transfer_testbus
);

    logic       pcs_bit0;
    logic       pcs_bit1;
    logic       pcs_tx;
    logic [1:0] pma_pair;

    // ------------------------------------------------------------------------
    // Source select
    // ------------------------------------------------------------------------
    always_comb begin
        case (tb_sel)
            TB_FIFO1:  rx_chnl_testbus = fifo_testbus1;
            TB_FIFO2:  rx_chnl_testbus = fifo_testbus2;
            TB_TXCHNL: rx_chnl_testbus = tx_chnl_testbus;
            TB_AVMM:   rx_chnl_testbus = avmm_testbus;
            TB_HRDRST: rx_chnl_testbus = hrdrst_testbus;
            TB_PLD:    rx_chnl_testbus = pld_test_data;
            TB_DLL:    rx_chnl_testbus = {{(`RX_TESTBUS_W - 13){1'b0}}, oaibdftdll2core};
            default:   rx_chnl_testbus = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // PCS slice, three adjacent bits per pcs_sel step
    // ------------------------------------------------------------------------
    always_comb begin
        pcs_bit1 = rx_chnl_testbus[2];
        pcs_tx   = rx_chnl_testbus[1];
        pcs_bit0 = rx_chnl_testbus[0];
        case (pcs_sel)
            3'd1: {pcs_bit1, pcs_tx, pcs_bit0} = rx_chnl_testbus[5:3];
            3'd2: {pcs_bit1, pcs_tx, pcs_bit0} = rx_chnl_testbus[8:6];
            3'd3: {pcs_bit1, pcs_tx, pcs_bit0} = rx_chnl_testbus[11:9];
            3'd4: {pcs_bit1, pcs_tx, pcs_bit0} = rx_chnl_testbus[14:12];
            3'd5: {pcs_bit1, pcs_tx, pcs_bit0} = rx_chnl_testbus[17:15];
            3'd6: begin
                // Word has no bit 20, bit1 keeps the k = 0 source
                {pcs_tx, pcs_bit0} = rx_chnl_testbus[19:18];
            end
            default: ;                      // 0 and 7 take bits 2..0
        endcase
    end

    // PMA pair 2m+1..2m, m from the low two select bits
    assign pma_pair = pld_pma_testbus[{pcs_sel[1:0], 1'b0} +: 2];

    assign rx_direct_transfer_testbus[0] = pcspma_sel ? pcs_bit0 : pma_pair[0];
    assign tx_direct_transfer_testbus    = pcspma_sel ? pcs_tx   : pma_pair[1];
    assign rx_direct_transfer_testbus[1] = pcs_bit1;   // Never bypassed

endmodule

`default_nettype wire

// File: logic/rx_chnl_debug_top.sv
// Receive channel debug subsystem top level
// Transmit-channel, PLD, PMA and DLL test words come in from outside

`timescale 1ns/100ps
`default_nettype none

`include "rx_testbus_defines.svh"

module rx_chnl_debug_top
    import rx_testbus_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         cfg_req,
    input  wire  [`RX_CFG_ADDR_W-1:0]   cfg_addr,
    input  wire  [`RX_CFG_DATA_W-1:0]   cfg_wdata,
    input  wire                         rx_data_valid,
    input  wire  [`RX_FIFO_DATA_W-1:0]  rx_data,
    input  wire                         rx_rd_en,
    input  wire                         hrdrst_req,
    input  testbus_t                    tx_chnl_testbus,
    input  testbus_t                    pld_test_data,
    input  wire  [7:0]                  pld_pma_testbus,
    input  wire  [12:0]                 oaibdftdll2core,
    output logic                        cfg_ack,
    output logic                        hrdrst_ack,
    output logic [`RX_FIFO_DATA_W-1:0]  rx_rd_data,
    output logic                        rx_empty,
    output logic                        rx_full,
    output testbus_t                    rx_chnl_testbus,
    output logic [1:0]                  rx_direct_transfer_testbus,
    output logic                        tx_direct_transfer_testbus
);

    tb_src_e    tb_sel;
    logic [2:0] pcs_sel;
    logic       pcspma_sel;
    logic       fifo_srst;
    testbus_t   avmm_testbus;
    testbus_t   fifo_testbus1;
    testbus_t   fifo_testbus2;
    testbus_t   hrdrst_testbus;

    rx_cfg_regs rx_cfg_regs_inst (
        .clk          (clk),
        .reset        (reset),
        .cfg_req      (cfg_req),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_ack      (cfg_ack),
        .tb_sel       (tb_sel),
        .pcs_sel      (pcs_sel),
        .pcspma_sel   (pcspma_sel),
        .avmm_testbus (avmm_testbus)
    );

    rx_fifo #(
        .DEPTH (`RX_FIFO_DEPTH)
    ) rx_fifo_inst (
        .clk           (clk),
        .reset         (reset),
        .fifo_srst     (fifo_srst),
        .rx_data_valid (rx_data_valid),
        .rx_data       (rx_data),
        .rx_rd_en      (rx_rd_en),
        .rx_rd_data    (rx_rd_data),
        .rx_empty      (rx_empty),
        .rx_full       (rx_full),
        .fifo_testbus1 (fifo_testbus1),
        .fifo_testbus2 (fifo_testbus2)
    );

    rx_hrdrst_ctrl rx_hrdrst_ctrl_inst (
        .clk            (clk),
        .reset          (reset),
        .hrdrst_req     (hrdrst_req),
        .hrdrst_ack     (hrdrst_ack),
        .fifo_srst      (fifo_srst),
        .hrdrst_testbus (hrdrst_testbus)
    );

    rx_chnl_testbus rx_chnl_testbus_inst (
        .tb_sel                     (tb_sel),
        .pcs_sel                    (pcs_sel),
        .pcspma_sel                 (pcspma_sel),
        .fifo_testbus1              (fifo_testbus1),
        .fifo_testbus2              (fifo_testbus2),
        .hrdrst_testbus             (hrdrst_testbus),
        .avmm_testbus               (avmm_testbus),
        .tx_chnl_testbus            (tx_chnl_testbus),
        .pld_test_data              (pld_test_data),
        .pld_pma_testbus            (pld_pma_testbus),
        .oaibdftdll2core            (oaibdftdll2core),
        .rx_chnl_testbus            (rx_chnl_testbus),
        .rx_direct_transfer_testbus (rx_direct_transfer_testbus),
        .tx_direct_transfer_testbus (tx_direct_transfer_testbus)
    );

endmodule

`default_nettype wire

// File: dv/tb_rx_chnl_debug.sv
// Random-stimulus testbench for the receive channel debug subsystem
// A cycle model runs on the rising edge; every output is checked on the falling edge
// rx_rd_data is compared only while the model FIFO holds data

`timescale 1ns/100ps
`default_nettype none

`include "rx_testbus_defines.svh"

module tb_rx_chnl_debug
    import rx_testbus_pkg::*;
();

    localparam int CFG_WRITES  = 40;
    localparam int FIFO_CYCLES = 150;
    // Twice the nominal length of all five tests
    localparam int CYCLE_LIMIT = 2 * (4 + (CFG_WRITES + 40) * 5 + 16 * 7
                                      + 2 * FIFO_CYCLES + 30 + 4 * `RX_HRDRST_DELAY);

    logic        clk = 1'b0;
    logic        reset, cfg_req, rx_data_valid, rx_rd_en, hrdrst_req;
    logic [3:0]  cfg_addr;
    logic [7:0]  cfg_wdata, pld_pma_testbus;
    logic [15:0] rx_data;
    logic [12:0] oaibdftdll2core;
    testbus_t    tx_chnl_testbus, pld_test_data;
    logic        cfg_ack, hrdrst_ack, rx_empty, rx_full, tx_direct_transfer_testbus;
    logic [15:0] rx_rd_data;
    testbus_t    rx_chnl_testbus;
    logic [1:0]  rx_direct_transfer_testbus;

    integer seed   = 62376;
    integer errors = 0;
    integer checks = 0;
    integer cycles = 0;
    string  test_name = "reset";

    // Reference model state
    logic          m_ack, m_pcspma, m_ovf, m_unf, was_full, was_empty;
    logic [3:0]    m_tb_sel, m_addr, m_wr_ptr, m_rd_ptr;
    logic [2:0]    m_pcs_sel;
    logic [7:0]    m_wr_cnt, m_data, m_hr_cnt;
    logic [15:0]   m_q[$];
    hrdrst_state_e m_hr_state;
    testbus_t      exp_bus;

    always #5 clk = ~clk;

    rx_chnl_debug_top rx_chnl_debug_top_inst (.*);

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        assert (actual === expected) else begin
            errors = errors + 1;
            $display("Error: %s %s expected %h actual %h at %0t",
                     test_name, what, expected, actual, $time);
        end
    endtask

    function automatic bit chance(input int pct);
        int unsigned r;
        r = $unsigned($random(seed));
        return (r % 100) < pct;
    endfunction

    function automatic testbus_t expected_bus();
        case (m_tb_sel)
            TB_FIFO1:  return {3'b000, m_rd_ptr, m_wr_ptr, m_unf, m_ovf, m_q.size() == 0,
                               m_q.size() == `RX_FIFO_DEPTH, 5'(m_q.size())};
            TB_FIFO2:  return (m_q.size() == 0) ? '0 : {4'b0000, m_q[0]};
            TB_TXCHNL: return tx_chnl_testbus;
            TB_AVMM:   return {m_wr_cnt, m_addr, m_data};
            TB_HRDRST: return {8'd0, m_hr_state == HR_DONE, hrdrst_req, m_hr_cnt, m_hr_state};
            TB_PLD:    return pld_test_data;
            TB_DLL:    return {7'd0, oaibdftdll2core};
            default:   return '0;
        endcase
    endfunction

    // Returns {tx, rx[1], rx[0]}
    function automatic logic [2:0] expected_direct(input testbus_t word);
        int k;
        int m;
        logic b0, b1, tx;
        logic [1:0] pair;
        k = (m_pcs_sel == 3'd7) ? 0 : int'(m_pcs_sel);
        m = int'(m_pcs_sel[1:0]);
        b0 = word[3 * k];
        tx = word[3 * k + 1];
        b1 = (3 * k + 2 < `RX_TESTBUS_W) ? word[3 * k + 2] : word[2];   // No bit 20
        pair = pld_pma_testbus[2 * m +: 2];
        return m_pcspma ? {tx, b1, b0} : {pair[1], b1, pair[0]};
    endfunction

    task automatic cfg_write(input logic [3:0] addr, input logic [7:0] data);
        int n;
        @(posedge clk);
        cfg_req   <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cfg_ack && n < 20);
        check_equal("ack rise edges", 2, n);
        @(posedge clk);
        cfg_req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (cfg_ack && n < 20);
        check_equal("ack fall edges", 2, n);
    endtask

    task automatic drive_sources();
        @(posedge clk);
        tx_chnl_testbus <= testbus_t'($random(seed));
        pld_test_data   <= testbus_t'($random(seed));
        pld_pma_testbus <= 8'($random(seed));
        oaibdftdll2core <= 13'($random(seed));
    endtask

    task automatic fifo_traffic(input int n, input int wr_pct, input int rd_pct);
        repeat (n) begin
            @(posedge clk);
            rx_data_valid <= chance(wr_pct);
            rx_data       <= 16'($random(seed));
            rx_rd_en      <= chance(rd_pct);
        end
        @(posedge clk);
        rx_data_valid <= 1'b0;
        rx_rd_en      <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Reference model sees the inputs as they were before the edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            m_ack = 1'b0;
            {m_tb_sel, m_pcs_sel, m_pcspma, m_wr_cnt, m_addr, m_data} = '0;
            m_q.delete();
            {m_wr_ptr, m_rd_ptr, m_ovf, m_unf} = '0;
            m_hr_state = HR_IDLE;
            m_hr_cnt   = 8'd0;
        end else begin
            if (m_hr_state == HR_RESET) begin   // Sequencer holds FIFO in reset
                m_q.delete();
                {m_wr_ptr, m_rd_ptr, m_ovf, m_unf} = '0;
            end else begin
                was_full  = (m_q.size() == `RX_FIFO_DEPTH);
                was_empty = (m_q.size() == 0);
                if (rx_rd_en && !was_empty) begin
                    m_q.delete(0);
                    m_rd_ptr = m_rd_ptr + 4'd1;
                end
                if (rx_data_valid && !was_full) begin
                    m_q.push_back(rx_data);
                    m_wr_ptr = m_wr_ptr + 4'd1;
                end
                if (rx_data_valid && was_full) m_ovf = 1'b1;
                if (rx_rd_en && was_empty)     m_unf = 1'b1;
            end
            if (cfg_req && !m_ack) begin
                m_ack    = 1'b1;
                m_wr_cnt = m_wr_cnt + 8'd1;
                m_addr   = cfg_addr;
                m_data   = cfg_wdata;
                if (cfg_addr == `RX_CFG_ADDR_DP_SEL) begin
                    m_tb_sel = cfg_wdata[3:0];
                end else if (cfg_addr == `RX_CFG_ADDR_PCS_SEL) begin
                    m_pcs_sel = cfg_wdata[2:0];
                    m_pcspma  = cfg_wdata[3];
                end
            end else if (m_ack && !cfg_req) begin
                m_ack = 1'b0;
            end
            case (m_hr_state)
                HR_IDLE: begin
                    if (hrdrst_req) begin
                        m_hr_state = HR_RESET;
                        m_hr_cnt   = 8'd0;
                    end
                end
                HR_RESET: begin
                    if (m_hr_cnt == 8'(`RX_HRDRST_DELAY - 1)) m_hr_state = HR_DONE;
                    else m_hr_cnt = m_hr_cnt + 8'd1;
                end
                default: if (!hrdrst_req) m_hr_state = HR_IDLE;
            endcase
        end
    end

    // Outputs are settled half a period after the drive edge
    always @(negedge clk) begin
        if (!reset) begin
            exp_bus = expected_bus();
            check_equal("cfg_ack", m_ack, cfg_ack);
            check_equal("hrdrst_ack", m_hr_state == HR_DONE, hrdrst_ack);
            check_equal("rx_empty", m_q.size() == 0, rx_empty);
            check_equal("rx_full", m_q.size() == `RX_FIFO_DEPTH, rx_full);
            if (m_q.size() != 0) check_equal("rx_rd_data", m_q[0], rx_rd_data);
            check_equal("rx_chnl_testbus", exp_bus, rx_chnl_testbus);
            check_equal("direct bits", expected_direct(exp_bus),
                        {tx_direct_transfer_testbus, rx_direct_transfer_testbus});
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int         n;
        logic [3:0] addr;
        logic [7:0] data;
        reset = 1'b1;
        {cfg_req, cfg_addr, cfg_wdata, rx_data_valid, rx_data, rx_rd_en} = '0;
        {hrdrst_req, tx_chnl_testbus, pld_test_data, pld_pma_testbus, oaibdftdll2core} = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        test_name = "cfg_handshake";
        cfg_write(`RX_CFG_ADDR_DP_SEL, 8'h59);   // AVMM word on the bus
        repeat (CFG_WRITES) begin
            addr = 4'($random(seed));
            data = 8'($random(seed));
            if (addr == `RX_CFG_ADDR_DP_SEL) data[3:0] = 4'd9;
            cfg_write(addr, data);
        end

        test_name = "source_select";
        for (int code = 0; code < 16; code++) begin
            cfg_write(`RX_CFG_ADDR_DP_SEL, {4'($random(seed)), 4'(code)});
            repeat (3) drive_sources();
        end

        test_name = "bit_slice";
        cfg_write(`RX_CFG_ADDR_DP_SEL, 8'h0c);   // Random PLD word as slice source
        for (int sel = 0; sel < 16; sel++) begin
            cfg_write(`RX_CFG_ADDR_PCS_SEL, {4'($random(seed)), 4'(sel)});
            repeat (4) drive_sources();
        end

        test_name = "fifo_traffic";
        cfg_write(`RX_CFG_ADDR_DP_SEL, 8'h00);
        fifo_traffic(FIFO_CYCLES, 80, 25);       // Runs into overflow
        cfg_write(`RX_CFG_ADDR_DP_SEL, 8'h01);
        fifo_traffic(FIFO_CYCLES, 25, 80);       // Drains into underflow
        cfg_write(`RX_CFG_ADDR_DP_SEL, 8'h00);

        test_name = "hard_reset";
        fifo_traffic(30, 100, 0);
        cfg_write(`RX_CFG_ADDR_DP_SEL, 8'h0b);
        @(posedge clk);
        hrdrst_req <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!hrdrst_ack && n < 4 * `RX_HRDRST_DELAY);
        // First falling edge comes before the first rising edge
        check_equal("ack latency", `RX_HRDRST_DELAY + 1, n - 1);
        @(posedge clk);
        hrdrst_req <= 1'b0;
        repeat (3) @(posedge clk);
        cfg_write(`RX_CFG_ADDR_DP_SEL, 8'h00);
        @(negedge clk);
        // Underflow, overflow, empty, full
        check_equal("flags after reset", 4'b0010, rx_chnl_testbus[8:5]);
        repeat (2) @(posedge clk);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/rx_testbus_pkg.sv
logic/rx_cfg_regs.sv
logic/rx_fifo.sv
logic/rx_hrdrst_ctrl.sv
logic/rx_chnl_testbus.sv
logic/rx_chnl_debug_top.sv
dv/tb_rx_chnl_debug.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the receive channel debug testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_rx_chnl_debug -o sim_rx_chnl_debug

if ! ./obj_dir/sim_rx_chnl_debug > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
